// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_trav_top -o tb_trav_top
	./obj_dir/tb_trav_top

clean:
	rm -rf obj_dir

// File: common/trav_pkg.sv
package trav_pkg;

  localparam int RAY_ID_W  = 8;
  localparam int NODE_ID_W = 12;
  localparam int TRI_ID_W  = 16;
  // unsigned Q8.8 distances along the ray
  localparam int T_W       = 16;
  // signed Q8.8 coordinates and inverse direction
  localparam int COORD_W   = 16;
  localparam int FRAC_W    = 8;
  // (split - orig) is one bit wider, product adds the inverse direction
  localparam int PROD_W    = 2 * COORD_W + 1;

  // leaf FIFO holds 2**LEAF_FIFO_K entries
  localparam int LEAF_FIFO_K = 2;

  typedef enum logic [1:0] {
    NODE_X    = 2'd0,
    NODE_Y    = 2'd1,
    NODE_Z    = 2'd2,
    NODE_LEAF = 2'd3
  } node_type_e;

  // interior node, high child is low_child + 1
  typedef struct packed {
    node_type_e                  node_type;
    logic signed [COORD_W-1:0]   split;
    logic        [NODE_ID_W-1:0] low_child;
  } norm_node_t;

  typedef struct packed {
    node_type_e          node_type;
    logic [TRI_ID_W-1:0] tri0_id;
    logic [TRI_ID_W-1:0] tri1_id;
    logic                tri1_valid;
  } leaf_node_t;

  localparam int NORM_PAD_W = $bits(leaf_node_t) - $bits(norm_node_t);

  // pad at the bottom so node_type lines up with the leaf view
  typedef struct packed {
    norm_node_t            node;
    logic [NORM_PAD_W-1:0] pad;
  } norm_pad_t;

  typedef union packed {
    leaf_node_t leaf;
    norm_pad_t  norm;
  } tree_node_t;

  // ray origin and inverse direction arrive already picked for the node axis
  typedef struct packed {
    logic        [RAY_ID_W-1:0]  ray_id;
    logic        [NODE_ID_W-1:0] node_id;
    tree_node_t                  tree_node;
    logic                        restnode_search;
    logic        [T_W-1:0]       t_min;
    logic        [T_W-1:0]       t_max;
    logic signed [COORD_W-1:0]   ray_orig;
    logic signed [COORD_W-1:0]   ray_inv_dir;
  } tcache_to_trav_t;

  typedef struct packed {
    logic        [RAY_ID_W-1:0]  ray_id;
    logic        [NODE_ID_W-1:0] node_id;
    norm_node_t                  node;
    logic                        restnode_search;
    logic        [T_W-1:0]       t_min;
    logic        [T_W-1:0]       t_max;
    logic signed [COORD_W-1:0]   ray_orig;
    logic signed [COORD_W-1:0]   ray_inv_dir;
  } trav_to_rs_t;

  // trav_case 0 low, 1 high, 2 low + push high, 3 high + push low
  typedef struct packed {
    logic [RAY_ID_W-1:0]  ray_id;
    logic [1:0]           trav_case;
    logic [NODE_ID_W-1:0] low_child;
    logic [T_W-1:0]       t_split;
    logic [T_W-1:0]       t_min;
    logic [T_W-1:0]       t_max;
    logic                 restnode_search;
  } rs_to_trav_t;

  typedef struct packed {
    logic [RAY_ID_W-1:0]  ray_id;
    logic [NODE_ID_W-1:0] node_id;
    logic [T_W-1:0]       t_min;
    logic [T_W-1:0]       t_max;
    logic                 restnode_search;
  } trav_to_tcache_t;

  typedef struct packed {
    logic [RAY_ID_W-1:0]  ray_id;
    logic [NODE_ID_W-1:0] node_id;
    logic [T_W-1:0]       t_min;
    logic [T_W-1:0]       t_max;
  } trav_to_ss_t;

  typedef struct packed {
    logic [RAY_ID_W-1:0] ray_id;
    logic [T_W-1:0]      t_max;
    logic [TRI_ID_W-1:0] tri0_id;
    logic [TRI_ID_W-1:0] tri1_id;
    logic                tri1_valid;
  } iarb_t;

endpackage

// File: hw/fifo.sv
`timescale 1ns/1ps

module fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  K         = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t data_in,
  input  logic     we,
  input  logic     re,
  output payload_t data_out,
  output logic     full,
  output logic     empty
);

  localparam int DEPTH = 2 ** K;

  payload_t   mem [DEPTH];
  // extra top bit tells full from empty
  logic [K:0] wr_ptr;
  logic [K:0] rd_ptr;

  assign empty    = (wr_ptr == rd_ptr);
  assign full     = (wr_ptr[K] != rd_ptr[K]) && (wr_ptr[K-1:0] == rd_ptr[K-1:0]);
  // show-ahead read
  assign data_out = mem[rd_ptr[K-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (re) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr[K-1:0]] <= data_in;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(we && full));
  assert property (@(posedge clk) disable iff (!rst_n) !(re && empty));

endmodule

// File: hw/trav_top.sv
`timescale 1ns/1ps

module trav_top (
  input  logic                      clk,
  input  logic                      rst_n,

  // node fetches from the tree cache
  input  logic                      tcache_to_trav_valid,
  input  trav_pkg::tcache_to_trav_t tcache_to_trav_data,
  output logic                      tcache_to_trav_stall,

  // leaf work for the intersection arbiter
  output logic                      trav_to_iarb_valid,
  output trav_pkg::iarb_t           trav_to_iarb_data,
  input  logic                      trav_to_iarb_stall,

  // next child fetch
  output logic                      trav_to_tcache_valid,
  output trav_pkg::trav_to_tcache_t trav_to_tcache_data,
  input  logic                      trav_to_tcache_stall,

  // far child push to the short stack
  output logic                      trav_to_ss_push_valid,
  output trav_pkg::trav_to_ss_t     trav_to_ss_push_data,
  input  logic                      trav_to_ss_push_stall
);

  logic                  trav_to_rs_valid;
  trav_pkg::trav_to_rs_t trav_to_rs_data;
  logic                  trav_to_rs_stall;

  logic                  rs_to_trav_valid;
  trav_pkg::rs_to_trav_t rs_to_trav_data;
  logic                  rs_to_trav_stall;

  trav_unit u_trav_unit (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .tcache_to_trav_valid  (tcache_to_trav_valid),
    .tcache_to_trav_data   (tcache_to_trav_data),
    .tcache_to_trav_stall  (tcache_to_trav_stall),
    .trav_to_rs_valid      (trav_to_rs_valid),
    .trav_to_rs_data       (trav_to_rs_data),
    .trav_to_rs_stall      (trav_to_rs_stall),
    .rs_to_trav_valid      (rs_to_trav_valid),
    .rs_to_trav_data       (rs_to_trav_data),
    .rs_to_trav_stall      (rs_to_trav_stall),
    .trav_to_tcache_valid  (trav_to_tcache_valid),
    .trav_to_tcache_data   (trav_to_tcache_data),
    .trav_to_tcache_stall  (trav_to_tcache_stall),
    .trav_to_ss_push_valid (trav_to_ss_push_valid),
    .trav_to_ss_push_data  (trav_to_ss_push_data),
    .trav_to_ss_push_stall (trav_to_ss_push_stall),
    .trav_to_iarb_valid    (trav_to_iarb_valid),
    .trav_to_iarb_data     (trav_to_iarb_data),
    .trav_to_iarb_stall    (trav_to_iarb_stall)
  );

  ray_split u_ray_split (
    .clk              (clk),
    .rst_n            (rst_n),
    .trav_to_rs_valid (trav_to_rs_valid),
    .trav_to_rs_data  (trav_to_rs_data),
    .trav_to_rs_stall (trav_to_rs_stall),
    .rs_to_trav_valid (rs_to_trav_valid),
    .rs_to_trav_data  (rs_to_trav_data),
    .rs_to_trav_stall (rs_to_trav_stall)
  );

endmodule

// File: hw/vs_buf.sv
`timescale 1ns/1ps

module vs_buf #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_us,
  input  payload_t data_us,
  output logic     stall_us,
  output logic     valid_ds,
  output payload_t data_ds,
  input  logic     stall_ds
);

  logic     skid_valid;
  payload_t skid_data;
  logic     accept_us;
  logic     load_ds;

  // upstream only sees the registered skid flag
  assign stall_us  = skid_valid;
  assign accept_us = valid_us & ~stall_us;
  assign load_ds   = ~valid_ds | ~stall_ds;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_ds   <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_ds) begin
      // skid entry drains first, input is blocked meanwhile
      valid_ds   <= skid_valid | accept_us;
      skid_valid <= 1'b0;
    end else if (accept_us) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_ds) begin
      data_ds <= skid_valid ? skid_data : data_us;
    end else if (accept_us) begin
      skid_data <= data_us;
    end
  end

  // held output must not change under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
    valid_ds && stall_ds |=> valid_ds && $stable(data_ds));

endmodule

// File: tb.f
+incdir+testbench
common/trav_pkg.sv
hw/vs_buf.sv
hw/fifo.sv
trav/ray_split.sv
trav/trav_unit.sv
hw/trav_top.sv
testbench/tb_trav_top.sv

// File: testbench/trav_model.svh
`ifndef TRAV_MODEL_SVH
`define TRAV_MODEL_SVH

// leaf fields go straight to the arbiter request
function automatic trav_pkg::iarb_t leaf_expect(input trav_pkg::tcache_to_trav_t n);
  trav_pkg::iarb_t r;
  r.ray_id     = n.ray_id;
  r.t_max      = n.t_max;
  r.tri0_id    = n.tree_node.leaf.tri0_id;
  r.tri1_id    = n.tree_node.leaf.tri1_id;
  r.tri1_valid = n.tree_node.leaf.tri1_valid;
  return r;
endfunction

// next fetch and optional far child push for an interior node
function automatic void split_expect(input trav_pkg::tcache_to_trav_t n,
                                     output trav_pkg::trav_to_tcache_t fetch,
                                     output trav_pkg::trav_to_ss_t push,
                                     output logic push_en);
  longint prod;
  longint t_full;
  logic [trav_pkg::T_W-1:0] t_split;
  logic [trav_pkg::NODE_ID_W-1:0] low_id;
  logic [trav_pkg::NODE_ID_W-1:0] high_id;
  logic [trav_pkg::NODE_ID_W-1:0] near_id;
  logic [trav_pkg::NODE_ID_W-1:0] far_id;
  prod = (longint'($signed(n.tree_node.norm.node.split)) - longint'($signed(n.ray_orig)))
         * longint'($signed(n.ray_inv_dir));
  t_full = prod >>> 8;
  if (prod < 64'sd0) begin
    t_split = '0;
  end else if (t_full > longint'(16'hffff)) begin
    t_split = '1;
  end else begin
    t_split = t_full[15:0];
  end
  low_id  = n.tree_node.norm.node.low_child;
  high_id = low_id + 1'b1;
  // negative direction meets the high side first
  near_id = n.ray_inv_dir[trav_pkg::COORD_W-1] ? high_id : low_id;
  far_id  = n.ray_inv_dir[trav_pkg::COORD_W-1] ? low_id : high_id;
  fetch.ray_id          = n.ray_id;
  fetch.restnode_search = n.restnode_search;
  fetch.t_min           = n.t_min;
  fetch.t_max           = n.t_max;
  push.ray_id  = n.ray_id;
  push.node_id = far_id;
  push.t_min   = t_split;
  push.t_max   = n.t_max;
  push_en      = 1'b0;
  if (prod < 64'sd0 || t_split > n.t_max) begin
    fetch.node_id = near_id;
  end else if (t_split < n.t_min) begin
    fetch.node_id = far_id;
  end else begin
    fetch.node_id = near_id;
    fetch.t_max   = t_split;
    push_en       = 1'b1;
  end
endfunction

`endif

// File: testbench/tb_trav_top.sv
`timescale 1ns/1ps

module tb_trav_top;

  logic                      clk;
  logic                      rst_n;
  logic                      tcache_to_trav_valid;
  trav_pkg::tcache_to_trav_t tcache_to_trav_data;
  logic                      tcache_to_trav_stall;
  logic                      trav_to_iarb_valid;
  trav_pkg::iarb_t           trav_to_iarb_data;
  logic                      trav_to_iarb_stall;
  logic                      trav_to_tcache_valid;
  trav_pkg::trav_to_tcache_t trav_to_tcache_data;
  logic                      trav_to_tcache_stall;
  logic                      trav_to_ss_push_valid;
  trav_pkg::trav_to_ss_t     trav_to_ss_push_data;
  logic                      trav_to_ss_push_stall;

  // stall mode, only changed on falling edges
  logic        stall_rand = 1'b0;
  logic        hold_iarb  = 1'b0;
  logic [31:0] lcg_state  = 32'd50;
  logic [31:0] stall_draw;

  int edge_cnt = 0;
  int accept_edge;
  int last_iarb_edge;
  int last_fetch_edge;
  int max_wait = 1000;
  int exp_n_iarb = 0;
  int exp_n_fetch = 0;
  int exp_n_push = 0;
  int got_n_iarb = 0;
  int got_n_fetch = 0;
  int got_n_push = 0;

  trav_pkg::iarb_t           exp_iarb[$];
  trav_pkg::trav_to_tcache_t exp_fetch[$];
  logic                      exp_joint[$];
  trav_pkg::trav_to_ss_t     exp_push[$];

  logic iarb_fire;
  logic fetch_fire;
  logic push_fire;

  `include "trav_model.svh"

  trav_top dut (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .tcache_to_trav_valid  (tcache_to_trav_valid),
    .tcache_to_trav_data   (tcache_to_trav_data),
    .tcache_to_trav_stall  (tcache_to_trav_stall),
    .trav_to_iarb_valid    (trav_to_iarb_valid),
    .trav_to_iarb_data     (trav_to_iarb_data),
    .trav_to_iarb_stall    (trav_to_iarb_stall),
    .trav_to_tcache_valid  (trav_to_tcache_valid),
    .trav_to_tcache_data   (trav_to_tcache_data),
    .trav_to_tcache_stall  (trav_to_tcache_stall),
    .trav_to_ss_push_valid (trav_to_ss_push_valid),
    .trav_to_ss_push_data  (trav_to_ss_push_data),
    .trav_to_ss_push_stall (trav_to_ss_push_stall)
  );

  assign iarb_fire  = trav_to_iarb_valid & ~trav_to_iarb_stall;
  assign fetch_fire = trav_to_tcache_valid & ~trav_to_tcache_stall;
  assign push_fire  = trav_to_ss_push_valid & ~trav_to_ss_push_stall;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    edge_cnt++;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic abort_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_values(input logic [127:0] got, input logic [127:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_idle(input string what);
    compare_values(128'({trav_to_iarb_valid, trav_to_tcache_valid, trav_to_ss_push_valid,
                         tcache_to_trav_stall}), 128'(0), what);
  endtask

  // output stalls drawn on the edge, driven just after it
  always @(posedge clk) begin
    stall_draw = lcg_next();
    #1;
    if (stall_rand) begin
      trav_to_iarb_stall    = (stall_draw[17:16] == 2'b00);
      trav_to_tcache_stall  = (stall_draw[19:18] == 2'b00);
      trav_to_ss_push_stall = (stall_draw[21:20] == 2'b00);
    end else begin
      trav_to_iarb_stall    = hold_iarb;
      trav_to_tcache_stall  = 1'b0;
      trav_to_ss_push_stall = 1'b0;
    end
  end

  function automatic trav_pkg::tcache_to_trav_t random_node(input logic leaf);
    trav_pkg::tcache_to_trav_t n;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    r0 = lcg_next();
    r1 = lcg_next();
    r2 = lcg_next();
    r3 = lcg_next();
    n = '0;
    n.ray_id          = r0[31:24];
    n.node_id         = r0[23:12];
    n.restnode_search = r0[11];
    n.t_min           = {3'b000, r1[31:19]};
    n.t_max           = n.t_min + {3'b000, r1[15:3]};
    n.ray_orig        = {{4{r2[31]}}, r2[31:20]};
    // now and then a steep ray so t_split saturates
    if (r0[7:5] == 3'b000) begin
      n.ray_inv_dir = r2[19:4];
    end else begin
      n.ray_inv_dir = {{5{r2[19]}}, r2[19:9]};
    end
    if (leaf) begin
      n.tree_node.leaf.node_type  = trav_pkg::NODE_LEAF;
      n.tree_node.leaf.tri0_id    = r3[31:16];
      n.tree_node.leaf.tri1_id    = r3[15:0];
      n.tree_node.leaf.tri1_valid = r2[3];
    end else begin
      n.tree_node.norm.node.node_type = trav_pkg::node_type_e'(r2[2:1] % 2'd3);
      n.tree_node.norm.node.split     = {{4{r3[31]}}, r3[31:20]};
      n.tree_node.norm.node.low_child = r3[15:4];
    end
    return n;
  endfunction

  task automatic model_accept(input trav_pkg::tcache_to_trav_t n);
    trav_pkg::trav_to_tcache_t fetch;
    trav_pkg::trav_to_ss_t     push;
    logic                      push_en;
    accept_edge = edge_cnt + 1;
    if (n.tree_node.leaf.node_type == trav_pkg::NODE_LEAF) begin
      exp_iarb.push_back(leaf_expect(n));
      exp_n_iarb++;
    end else begin
      split_expect(n, fetch, push, push_en);
      exp_fetch.push_back(fetch);
      exp_joint.push_back(push_en);
      exp_n_fetch++;
      if (push_en) begin
        exp_push.push_back(push);
        exp_n_push++;
      end
    end
  endtask

  // called just after a rising edge, returns just after a later one
  task automatic send_node(input trav_pkg::tcache_to_trav_t n);
    int waited;
    waited = 0;
    tcache_to_trav_valid = 1'b1;
    tcache_to_trav_data  = n;
    @(negedge clk);
    while (tcache_to_trav_stall) begin
      waited++;
      if (waited > max_wait) begin
        abort_run("input stall did not clear in time");
      end
      @(negedge clk);
    end
    model_accept(n);
    @(posedge clk);
    #1;
    tcache_to_trav_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_iarb.size() + exp_fetch.size() + exp_push.size() != 0) begin
      waited++;
      if (waited > max_wait) begin
        abort_run("expected outputs did not all arrive in time");
      end
      @(posedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic set_stalls(input logic rand_en, input logic hold);
    @(negedge clk);
    stall_rand = rand_en;
    hold_iarb  = hold;
    @(posedge clk);
    #1;
  endtask

  // transfers seen at the falling edge complete on the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      check_idle("output active during reset");
    end else begin
      if (iarb_fire) begin
        if (exp_iarb.size() == 0) begin
          abort_run("leaf request with no leaf pending");
        end else begin
          compare_values(128'(trav_to_iarb_data), 128'(exp_iarb.pop_front()), "leaf request");
          got_n_iarb++;
          last_iarb_edge = edge_cnt + 1;
        end
      end
      if (fetch_fire) begin
        if (exp_fetch.size() == 0) begin
          abort_run("child fetch with no interior node pending");
        end else begin
          compare_values(128'(trav_to_tcache_data), 128'(exp_fetch.pop_front()),
                         "child fetch");
          // a push goes with the fetch exactly when the model splits the interval
          compare_values(128'(push_fire), 128'(exp_joint.pop_front()),
                         "push together with fetch");
          got_n_fetch++;
          last_fetch_edge = edge_cnt + 1;
        end
      end
      if (push_fire) begin
        if (exp_push.size() == 0) begin
          abort_run("stack push for a node that needs none");
        end else begin
          compare_values(128'(fetch_fire), 128'(1), "fetch together with push");
          compare_values(128'(trav_to_ss_push_data), 128'(exp_push.pop_front()),
                         "stack push");
          got_n_push++;
        end
      end
    end
  end

  initial begin
    trav_pkg::tcache_to_trav_t leaf_item;
    int accepted;
    int stalled_run;
    rst_n                 = 1'b0;
    tcache_to_trav_valid  = 1'b0;
    tcache_to_trav_data   = '0;
    trav_to_iarb_stall    = 1'b0;
    trav_to_tcache_stall  = 1'b0;
    trav_to_ss_push_stall = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle("output active right after reset");
    end
    @(posedge clk);
    #1;

    // single leaf and single interior node latency
    send_node(random_node(1'b1));
    wait_drain();
    compare_values(128'(last_iarb_edge - accept_edge), 128'(2), "leaf latency");
    send_node(random_node(1'b0));
    wait_drain();
    compare_values(128'(last_fetch_edge - accept_edge), 128'(3), "interior latency");

    repeat (300) send_node(random_node(1'b0));
    wait_drain();
    compare_values(128'(got_n_fetch), 128'(exp_n_fetch), "interior fetch count");

    // mixed traffic against random back-pressure
    set_stalls(1'b1, 1'b0);
    repeat (300) send_node(random_node(((lcg_next() >> 16) % 32'd3) == 32'd0));
    set_stalls(1'b0, 1'b0);
    wait_drain();

    // leaf path blocked at the arbiter
    set_stalls(1'b0, 1'b1);
    accepted    = 0;
    stalled_run = 0;
    leaf_item   = random_node(1'b1);
    tcache_to_trav_valid = 1'b1;
    tcache_to_trav_data  = leaf_item;
    while (stalled_run < 4) begin
      @(negedge clk);
      if (!tcache_to_trav_stall) begin
        model_accept(leaf_item);
        accepted++;
        stalled_run = 0;
        if (accepted > 20) begin
          abort_run("input never stalled with the leaf path blocked");
        end
        @(posedge clk);
        #1;
        leaf_item           = random_node(1'b1);
        tcache_to_trav_data = leaf_item;
      end else begin
        stalled_run++;
        @(posedge clk);
        #1;
      end
    end
    // four FIFO entries plus both skid buffer entries
    compare_values(128'(accepted), 128'(6), "leaves accepted while blocked");
    set_stalls(1'b0, 1'b0);
    send_node(leaf_item);
    wait_drain();

    compare_values(128'(got_n_iarb), 128'(exp_n_iarb), "leaf request count");
    compare_values(128'(got_n_fetch), 128'(exp_n_fetch), "child fetch count");
    compare_values(128'(got_n_push), 128'(exp_n_push), "stack push count");
    repeat (10) @(posedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: trav/ray_split.sv
`timescale 1ns/1ps

module ray_split (
  input  logic                  clk,
  input  logic                  rst_n,

  // trav to rs
  input  logic                  trav_to_rs_valid,
  input  trav_pkg::trav_to_rs_t trav_to_rs_data,
  output logic                  trav_to_rs_stall,

  // rs to trav
  output logic                  rs_to_trav_valid,
  output trav_pkg::rs_to_trav_t rs_to_trav_data,
  input  logic                  rs_to_trav_stall
);

  localparam int P_W  = trav_pkg::PROD_W;
  localparam int T_W  = trav_pkg::T_W;
  localparam int FR_W = trav_pkg::FRAC_W;

  logic                          advance;
  logic signed [trav_pkg::COORD_W:0] diff;
  logic signed [P_W-1:0]         prod;

  logic                          s1_valid;
  trav_pkg::trav_to_rs_t         s1_data;
  logic signed [P_W-1:0]         s1_prod;

  logic                          neg;
  logic                          near_high;
  logic [T_W-1:0]                t_split;
  logic [1:0]                    trav_case;

  // whole pipe freezes on output stall
  assign advance          = ~rs_to_trav_stall;
  assign trav_to_rs_stall = rs_to_trav_stall;

  // Q8.8 * Q8.8 leaves 16 fraction bits in the product
  assign diff = trav_to_rs_data.node.split - trav_to_rs_data.ray_orig;
  assign prod = diff * trav_to_rs_data.ray_inv_dir;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid         <= 1'b0;
      rs_to_trav_valid <= 1'b0;
    end else if (advance) begin
      s1_valid         <= trav_to_rs_valid;
      rs_to_trav_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_data <= trav_to_rs_data;
      s1_prod <= prod;
    end
  end

  // scale back by 8, clamp to 0..all-ones
  assign neg       = s1_prod[P_W-1];
  assign near_high = s1_data.ray_inv_dir[trav_pkg::COORD_W-1];

  always_comb begin
    if (neg) begin
      t_split = '0;
    end else if (|s1_prod[P_W-2:T_W+FR_W]) begin
      t_split = '1;
    end else begin
      t_split = s1_prod[T_W+FR_W-1:FR_W];
    end

    if (neg || (t_split > s1_data.t_max)) begin
      // near child only
      trav_case = {1'b0, near_high};
    end else if (t_split < s1_data.t_min) begin
      // far child only
      trav_case = {1'b0, ~near_high};
    end else begin
      trav_case = {1'b1, near_high};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      rs_to_trav_data.ray_id          <= s1_data.ray_id;
      rs_to_trav_data.trav_case       <= trav_case;
      rs_to_trav_data.low_child       <= s1_data.node.low_child;
      rs_to_trav_data.t_split         <= t_split;
      rs_to_trav_data.t_min           <= s1_data.t_min;
      rs_to_trav_data.t_max           <= s1_data.t_max;
      rs_to_trav_data.restnode_search <= s1_data.restnode_search;
    end
  end

  // a push is only ever issued for a split inside the interval
  assert property (@(posedge clk) disable iff (!rst_n)
    rs_to_trav_valid && rs_to_trav_data.trav_case[1] |->
      (rs_to_trav_data.t_split >= rs_to_trav_data.t_min) &&
      (rs_to_trav_data.t_split <= rs_to_trav_data.t_max));

endmodule

// File: trav/trav_unit.sv
`timescale 1ns/1ps

module trav_unit (
  input  logic                      clk,
  input  logic                      rst_n,

  // tcache to trav
  input  logic                      tcache_to_trav_valid,
  input  trav_pkg::tcache_to_trav_t tcache_to_trav_data,
  output logic                      tcache_to_trav_stall,

  // trav to rs
  output logic                      trav_to_rs_valid,
  output trav_pkg::trav_to_rs_t     trav_to_rs_data,
  input  logic                      trav_to_rs_stall,

  // rs to trav
  input  logic                      rs_to_trav_valid,
  input  trav_pkg::rs_to_trav_t     rs_to_trav_data,
  output logic                      rs_to_trav_stall,

  // trav to tcache, next node fetch
  output logic                      trav_to_tcache_valid,
  output trav_pkg::trav_to_tcache_t trav_to_tcache_data,
  input  logic                      trav_to_tcache_stall,

  // trav to ss, push
  output logic                      trav_to_ss_push_valid,
  output trav_pkg::trav_to_ss_t     trav_to_ss_push_data,
  input  logic                      trav_to_ss_push_stall,

  // trav to iarb
  output logic                      trav_to_iarb_valid,
  output trav_pkg::iarb_t           trav_to_iarb_data,
  input  logic                      trav_to_iarb_stall
);

  logic                      buf_valid;
  trav_pkg::tcache_to_trav_t buf_data;
  logic                      buf_stall;
  logic                      is_leaf;

  trav_pkg::iarb_t           leaf_in;
  logic                      leaf_we;
  logic                      leaf_re;
  logic                      leaf_full;
  logic                      leaf_empty;

  logic [trav_pkg::NODE_ID_W-1:0] high_child;
  logic                      need_push;
  logic                      rs_accept;

  vs_buf #(
    .payload_t(trav_pkg::tcache_to_trav_t)
  ) in_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_us (tcache_to_trav_valid),
    .data_us  (tcache_to_trav_data),
    .stall_us (tcache_to_trav_stall),
    .valid_ds (buf_valid),
    .data_ds  (buf_data),
    .stall_ds (buf_stall)
  );

  assign is_leaf = (buf_data.tree_node.leaf.node_type == trav_pkg::NODE_LEAF);

  // leaves wait only on the FIFO, interior nodes on ray_split
  assign buf_stall = buf_valid & (is_leaf ? leaf_full : trav_to_rs_stall);
  assign leaf_we   = buf_valid & is_leaf & ~leaf_full;

  always_comb begin
    leaf_in.ray_id     = buf_data.ray_id;
    leaf_in.t_max      = buf_data.t_max;
    leaf_in.tri0_id    = buf_data.tree_node.leaf.tri0_id;
    leaf_in.tri1_id    = buf_data.tree_node.leaf.tri1_id;
    leaf_in.tri1_valid = buf_data.tree_node.leaf.tri1_valid;
  end

  fifo #(
    .payload_t (trav_pkg::iarb_t),
    .K         (trav_pkg::LEAF_FIFO_K)
  ) leaf_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_in  (leaf_in),
    .we       (leaf_we),
    .re       (leaf_re),
    .data_out (trav_to_iarb_data),
    .full     (leaf_full),
    .empty    (leaf_empty)
  );

  assign trav_to_iarb_valid = ~leaf_empty;
  assign leaf_re            = trav_to_iarb_valid & ~trav_to_iarb_stall;

  // interior nodes to ray_split
  assign trav_to_rs_valid = buf_valid & ~is_leaf;

  always_comb begin
    trav_to_rs_data.ray_id          = buf_data.ray_id;
    trav_to_rs_data.node_id         = buf_data.node_id;
    trav_to_rs_data.node            = buf_data.tree_node.norm.node;
    trav_to_rs_data.restnode_search = buf_data.restnode_search;
    trav_to_rs_data.t_min           = buf_data.t_min;
    trav_to_rs_data.t_max           = buf_data.t_max;
    trav_to_rs_data.ray_orig        = buf_data.ray_orig;
    trav_to_rs_data.ray_inv_dir     = buf_data.ray_inv_dir;
  end

  // split result fan-out, case bit 0 selects the high child
  assign high_child = rs_to_trav_data.low_child + 1'b1;
  assign need_push  = rs_to_trav_data.trav_case[1];

  // both channels must be free, otherwise neither fires
  assign rs_accept = rs_to_trav_valid & ~trav_to_tcache_stall
                   & ~(need_push & trav_to_ss_push_stall);
  assign rs_to_trav_stall      = rs_to_trav_valid & ~rs_accept;
  assign trav_to_tcache_valid  = rs_to_trav_valid & ~(need_push & trav_to_ss_push_stall);
  assign trav_to_ss_push_valid = rs_to_trav_valid & need_push & ~trav_to_tcache_stall;

  always_comb begin
    trav_to_tcache_data.ray_id          = rs_to_trav_data.ray_id;
    trav_to_tcache_data.node_id         = rs_to_trav_data.trav_case[0] ? high_child
                                                                       : rs_to_trav_data.low_child;
    trav_to_tcache_data.t_min           = rs_to_trav_data.t_min;
    trav_to_tcache_data.t_max           = need_push ? rs_to_trav_data.t_split
                                                    : rs_to_trav_data.t_max;
    trav_to_tcache_data.restnode_search = rs_to_trav_data.restnode_search;

    // far child resumes from the split point
    trav_to_ss_push_data.ray_id  = rs_to_trav_data.ray_id;
    trav_to_ss_push_data.node_id = rs_to_trav_data.trav_case[0] ? rs_to_trav_data.low_child
                                                                : high_child;
    trav_to_ss_push_data.t_min   = rs_to_trav_data.t_split;
    trav_to_ss_push_data.t_max   = rs_to_trav_data.t_max;
  end

endmodule
